/* compile.f */
verilog/rv_isa_pkg.sv
verilog/ex_types_pkg.sv
verilog/int_alu.sv
verilog/div_fsm.sv
verilog/div_step_counter.sv
verilog/div_datapath.sv
verilog/exec_unit.sv
tb/tb_exec_unit.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_exec_unit -f compile.f &&
    out="$(./obj_dir/Vtb_exec_unit)" ||
    { printf '%s\n' "${out:-}"; echo "build or simulation failed"; exit 1; }

printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "No errors" &&
    echo "simulation passed" ||
    { echo "simulation failed"; exit 1; }

/* tb/tb_exec_unit.sv */
// Directed tests with one divide at a time, and the run stops after 70 cycles per planned operation.
`timescale 1ns/1ps

module tb_exec_unit;
    import rv_isa_pkg::*;
    import ex_types_pkg::*;

    localparam int NUM_OPS    = 63;
    localparam int MAX_CYCLES = NUM_OPS * 70;
    localparam int ALU_EDGES  = 0;        // result is registered on the accepting edge.
    localparam int DIV_EDGES  = XLEN + 1;

    logic        clk;
    logic        rst_n;
    logic        req_valid;
    ex_req_t     req;
    logic        req_ready;
    logic        rsp_valid;
    ex_rsp_t     rsp;
    logic        rsp_ready;
    logic [15:0] lfsr;
    logic        req_taken;
    int          cycles;
    int          checks;
    int          errors;
    ex_rsp_t     exp_q [$];
    ex_op_e      alu_ops [12] = '{
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU, OP_XOR,
        OP_SRL, OP_SRA, OP_OR, OP_AND, OP_ADDW, OP_SUBW
    };

    exec_unit dut (
        .clk         (clk),
        .i_rst_n     (rst_n),
        .i_req_valid (req_valid),
        .i_req       (req),
        .o_req_ready (req_ready),
        .o_rsp_valid (rsp_valid),
        .o_rsp       (rsp),
        .i_rsp_ready (rsp_ready)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("timeout after %0d cycles, a response never arrived", cycles);
            $display("Errors found");
            $finish;
        end
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    // one lfsr step per bit taken.
    function automatic xlen_t rand_bits(input int n);
        xlen_t v;
        int    i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[XLEN-2:0], lfsr[0]};
        end
        return v;
    endfunction

    // reference results straight from the riscv rules.
    function automatic xlen_t ref_result(input ex_op_e op, input xlen_t a, input xlen_t b);
        xlen_t       ones;
        logic [31:0] w;
        int          sh;
        ones = '1;
        sh   = int'(b[5:0]);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_SLL:  return a << sh;
            OP_SLT:  return (a[63] != b[63]) ? xlen_t'(a[63]) : xlen_t'(a < b);
            OP_SLTU: return xlen_t'(a < b);
            OP_XOR:  return a ^ b;
            OP_SRL:  return a >> sh;
            OP_SRA:  return (a >> sh) | (a[63] ? ~(ones >> sh) : '0);
            OP_OR:   return a | b;
            OP_AND:  return a & b;
            OP_ADDW: begin
                w = a[31:0] + b[31:0];
                return {{32{w[31]}}, w};
            end
            OP_SUBW: begin
                w = a[31:0] - b[31:0];
                return {{32{w[31]}}, w};
            end
            OP_DIVU: return (b == '0) ? ones : a / b;
            OP_REMU: return (b == '0) ? a : a % b;
            default: return '0;
        endcase
    endfunction

    function automatic ex_req_t make_req(input ex_op_e op, input xlen_t a, input xlen_t b);
        ex_req_t r;
        r.op      = op;
        r.rs1_val = a;
        r.rs2_val = b;
        r.rd      = reg_idx_t'(rand_bits(5));
        return r;
    endfunction

    function automatic ex_rsp_t expected_rsp(input ex_req_t r);
        ex_rsp_t w;
        w.rd    = r.rd;
        w.value = ref_result(r.op, r.rs1_val, r.rs2_val);
        return w;
    endfunction

    task automatic check_value(input string name, input xlen_t got, input xlen_t want);
        checks++;
        assert (got == want) else begin
            errors++;
            $display("FAIL %0t %s got %h expected %h", $time, name, got, want);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("%0t: %s", $time, what);
        end
    endtask

    // drive on the falling edge, then note what the next rising edge transfers.
    task automatic drive_cycle(input logic valid, input ex_req_t r, input logic rdy);
        ex_rsp_t want;
        @(negedge clk);
        req_valid = valid;
        req       = r;
        rsp_ready = rdy;
        #1;
        req_taken = req_valid && req_ready;
        if (rsp_valid && rsp_ready) begin
            check_true(exp_q.size() > 0, "a response arrived that nobody asked for");
            if (exp_q.size() > 0) begin
                want = exp_q.pop_front();
                check_value("o_rsp.rd", xlen_t'(rsp.rd), xlen_t'(want.rd));
                check_value("o_rsp.value", rsp.value, want.value);
            end
        end
    endtask

    task automatic send(input ex_req_t r, input logic rdy);
        drive_cycle(1'b1, r, rdy);
        while (!req_taken) begin
            drive_cycle(1'b1, r, rdy);
        end
        exp_q.push_back(expected_rsp(r));
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (exp_q.size() > 0 && n < 100) begin
            drive_cycle(1'b0, '0, 1'b1);
            n++;
        end
        check_true(exp_q.size() == 0, "expected responses never came back");
    endtask

    // one request, then count edges until its response shows up.
    task automatic run_one(input ex_op_e op, input xlen_t a, input xlen_t b);
        int edges;
        send(make_req(op, a, b), 1'b1);
        edges = 0;
        drive_cycle(1'b0, '0, 1'b1);
        while (!rsp_valid) begin
            if (op_is_div(op)) begin
                check_true(!req_ready, "o_req_ready was high while a divide ran");
            end
            edges++;
            drive_cycle(1'b0, '0, 1'b1);
        end
        check_value("response edges", xlen_t'(edges),
                    xlen_t'(op_is_div(op) ? DIV_EDGES : ALU_EDGES));
    endtask

    task automatic check_reset();
        #1;
        check_value("o_rsp_valid", xlen_t'(rsp_valid), '0);
        check_value("o_req_ready", xlen_t'(req_ready), xlen_t'(1));
    endtask

    task automatic test_alu_random();
        xlen_t a;
        xlen_t b;
        int    i;
        int    k;
        for (i = 0; i < 12; i++) begin
            for (k = 0; k < 3; k++) begin
                a = rand_bits(64);
                b = rand_bits(64);
                run_one(alu_ops[i], a, b);
            end
        end
    endtask

    task automatic test_alu_edges();
        run_one(OP_ADDW, 64'hffff_0000_7fff_ffff, 64'h1);    // bit 31 set after the add.
        run_one(OP_SUBW, 64'h0, 64'h1);
        run_one(OP_SLL, 64'h0123_4567_89ab_cdef, 64'h47);   // 71 shifts by 7.
        run_one(OP_SRL, 64'hf000_0000_0000_0001, 64'hffff_ffff_ffff_ffc1);
        run_one(OP_SRA, 64'h8000_0000_0000_0100, 64'h7f);
        run_one(OP_SLT, 64'hffff_ffff_ffff_fffe, 64'h5);
    endtask

    task automatic test_divide();
        xlen_t a;
        xlen_t b;
        int    i;
        for (i = 0; i < 4; i++) begin
            a = rand_bits(64);
            b = rand_bits(8 + i * 16);  // divisor widths 8 to 56 bits.
            run_one(OP_DIVU, a, b);
            run_one(OP_REMU, a, b);
        end
        a = rand_bits(64);
        run_one(OP_DIVU, a, '0);
        run_one(OP_REMU, a, '0);
        a = rand_bits(16);
        b = rand_bits(64);
        run_one(OP_DIVU, a, b);
    endtask

    task automatic test_back_pressure();
        ex_req_t r2;
        ex_rsp_t held;
        r2 = make_req(OP_REMU, rand_bits(64), rand_bits(32));
        send(make_req(OP_XOR, rand_bits(64), rand_bits(64)), 1'b0);
        drive_cycle(1'b1, r2, 1'b0);
        check_value("o_rsp_valid", xlen_t'(rsp_valid), xlen_t'(1));
        held = rsp;
        repeat (5) begin
            drive_cycle(1'b1, r2, 1'b0);
            check_true(!req_taken, "a request was accepted while the response was stalled");
            check_true(rsp_valid && rsp == held, "o_rsp changed while stalled");
        end
        send(r2, 1'b1);  // stalled response drains on the same edge.
        drain();
    endtask

    task automatic test_streaming();
        ex_req_t r;
        int      i;
        for (i = 0; i < 8; i++) begin
            r = make_req(alu_ops[i], rand_bits(64), rand_bits(64));
            drive_cycle(1'b1, r, 1'b1);
            check_true(req_taken, "a back-to-back request was not accepted");
            if (i > 0) begin
                check_true(rsp_valid, "a streamed response skipped a cycle");
            end
            if (req_taken) begin
                exp_q.push_back(expected_rsp(r));
            end
        end
        drain();
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        rsp_ready = 1'b0;
        lfsr      = 16'd27680;
        cycles    = 0;
        checks    = 0;
        errors    = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_reset();
        test_alu_random();
        test_alu_edges();
        test_divide();
        test_back_pressure();
        test_streaming();
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* verilog/div_datapath.sv */
// Unsigned restoring divider with one quotient bit per step, and divide by zero needs no special case.
`timescale 1ns/1ps

module div_datapath (
    input  logic                clk,
    input  logic                i_rst_n,
    input  logic                i_load,
    input  logic                i_step,
    input  ex_types_pkg::xlen_t i_dividend,
    input  ex_types_pkg::xlen_t i_divisor,
    output ex_types_pkg::xlen_t o_quotient,
    output ex_types_pkg::xlen_t o_remainder
);
    import ex_types_pkg::*;

    xlen_t         rem_q;
    xlen_t         quo_q;   // dividend bits shift out, quotient bits shift in.
    xlen_t         dvs_q;
    logic [XLEN:0] shifted;
    logic [XLEN:0] diff;
    logic          fits;

    assign shifted = {rem_q, quo_q[XLEN-1]};
    assign diff    = shifted - {1'b0, dvs_q};
    assign fits    = (shifted >= {1'b0, dvs_q}); // always true for a zero divisor.

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            rem_q <= '0;
            quo_q <= '0;
            dvs_q <= '0;
        end else if (i_load) begin
            rem_q <= '0;
            quo_q <= i_dividend;
            dvs_q <= i_divisor;
        end else if (i_step) begin
            if (fits) begin
                rem_q <= diff[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b1};
            end else begin
                rem_q <= shifted[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b0};
            end
        end
    end

    // zero divisor ends with all-ones quotient and remainder equal to the dividend.
    assign o_quotient  = quo_q;
    assign o_remainder = rem_q;

endmodule

/* verilog/div_fsm.sv */
// Sequences one divide at a time, and a finished result waits in DONE until i_accept.
`timescale 1ns/1ps

module div_fsm (
    input  logic clk,
    input  logic i_rst_n,
    input  logic i_start,
    input  logic i_last,
    input  logic i_accept,
    output logic o_busy,
    output logic o_load,
    output logic o_step,
    output logic o_done
);
    typedef enum logic [1:0] {
        S_IDLE,
        S_RUN,
        S_DONE
    } div_state_e;

    div_state_e state;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (i_start) begin
                        state <= S_RUN;
                    end
                end
                S_RUN: begin
                    if (i_last) begin
                        state <= S_DONE; // 64th step completes here.
                    end
                end
                S_DONE: begin
                    if (i_accept) begin
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    assign o_busy = (state != S_IDLE);
    assign o_load = (state == S_IDLE) && i_start; // operands load on the accepting edge.
    assign o_step = (state == S_RUN);
    assign o_done = (state == S_DONE);

    // the top level must not start a second divide while one is in flight.
    a_start_idle: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_start |-> state == S_IDLE);

    // counter and fsm stay in step.
    a_last_run: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_last |-> state == S_RUN);

endmodule

/* verilog/div_step_counter.sv */
// Counts XLEN divider steps per load, and o_last stays low once the run is used up.
`timescale 1ns/1ps

module div_step_counter (
    input  logic clk,
    input  logic i_rst_n,
    input  logic i_load,
    input  logic i_step,
    output logic o_last
);
    import ex_types_pkg::*;

    step_cnt_t count;
    logic      spent;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            count <= '0;
            spent <= 1'b1;
        end else if (i_load) begin
            count <= step_cnt_t'(XLEN - 1);
            spent <= 1'b0;
        end else if (i_step) begin
            if (count == '0) begin
                spent <= 1'b1; // final step taken.
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    assign o_last = (count == '0) && !spent;

    // a step past the end would mean the fsm missed o_last.
    a_no_overrun: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_step && !i_load |-> !spent);

endmodule

/* verilog/ex_types_pkg.sv */
// Widths are fixed at RV64, and rv_isa_pkg must be compiled before this package.
package ex_types_pkg;

    localparam int XLEN = 64;

    typedef logic [XLEN-1:0] xlen_t;     // operand or result value.
    typedef logic [4:0]      reg_idx_t;  // destination register index.
    typedef logic [5:0]      shamt_t;    // shift amount, low 6 bits of rs2.
    typedef logic [5:0]      step_cnt_t; // divider iteration count.

    // one decoded operation entering the execute stage.
    typedef struct packed {
        rv_isa_pkg::ex_op_e op;
        xlen_t              rs1_val;
        xlen_t              rs2_val; // already extended by decode.
        reg_idx_t           rd;
    } ex_req_t;

    // result tagged with its destination register.
    typedef struct packed {
        reg_idx_t rd;
        xlen_t    value;
    } ex_rsp_t;

endpackage

/* verilog/exec_unit.sv */
// One divide in flight at a time, and single-cycle ops stream only while the response register drains.
`timescale 1ns/1ps

module exec_unit (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_req_valid,
    input  ex_types_pkg::ex_req_t i_req,
    output logic                  o_req_ready,
    output logic                  o_rsp_valid,
    output ex_types_pkg::ex_rsp_t o_rsp,
    input  logic                  i_rsp_ready
);
    import rv_isa_pkg::*;
    import ex_types_pkg::*;

    logic     req_fire;
    logic     div_start;
    logic     rsp_free;
    logic     div_busy;
    logic     div_load;
    logic     div_step;
    logic     div_last;
    logic     div_done;
    xlen_t    alu_result;
    xlen_t    quotient;
    xlen_t    remainder;
    ex_op_e   div_op_q;
    reg_idx_t div_rd_q;
    ex_rsp_t  rsp_q;
    logic     rsp_valid_q;

    assign rsp_free    = !rsp_valid_q || i_rsp_ready; // empty or emptied this cycle.
    assign o_req_ready = !div_busy && rsp_free;
    assign req_fire    = i_req_valid && o_req_ready;
    assign div_start   = req_fire && op_is_div(i_req.op);

    int_alu u_alu (
        .i_op     (i_req.op),
        .i_a      (i_req.rs1_val),
        .i_b      (i_req.rs2_val),
        .o_result (alu_result)
    );

    div_fsm u_div_fsm (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_start  (div_start),
        .i_last   (div_last),
        .i_accept (rsp_free),
        .o_busy   (div_busy),
        .o_load   (div_load),
        .o_step   (div_step),
        .o_done   (div_done)
    );

    div_step_counter u_div_cnt (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_load  (div_load),
        .i_step  (div_step),
        .o_last  (div_last)
    );

    div_datapath u_div_dp (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_load      (div_load),
        .i_step      (div_step),
        .i_dividend  (i_req.rs1_val),
        .i_divisor   (i_req.rs2_val),
        .o_quotient  (quotient),
        .o_remainder (remainder)
    );

    always_ff @(posedge clk) begin
        if (div_start) begin
            div_op_q <= i_req.op;
            div_rd_q <= i_req.rd;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            rsp_valid_q <= 1'b0;
        end else if (req_fire && !op_is_div(i_req.op)) begin
            rsp_valid_q <= 1'b1;
            rsp_q       <= '{rd: i_req.rd, value: alu_result};
        end else if (div_done && rsp_free) begin
            rsp_valid_q <= 1'b1;
            rsp_q.rd    <= div_rd_q;
            rsp_q.value <= (div_op_q == OP_DIVU) ? quotient : remainder;
        end else if (i_rsp_ready) begin
            rsp_valid_q <= 1'b0;
        end
    end

    assign o_rsp_valid = rsp_valid_q;
    assign o_rsp       = rsp_q;

    // a stalled response must not change or vanish.
    a_rsp_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_rsp_valid && !i_rsp_ready |=> o_rsp_valid && $stable(o_rsp));

endmodule

/* verilog/int_alu.sv */
// Purely combinational, so divide ops and unknown codes give zero and shifts use rs2 bits 5:0.
`timescale 1ns/1ps

module int_alu (
    input  rv_isa_pkg::ex_op_e  i_op,
    input  ex_types_pkg::xlen_t i_a,
    input  ex_types_pkg::xlen_t i_b,
    output ex_types_pkg::xlen_t o_result
);
    import rv_isa_pkg::*;
    import ex_types_pkg::*;

    shamt_t      shamt;
    logic [31:0] word_res;

    assign shamt = i_b[5:0];

    // shared 32-bit adder for addw and subw.
    assign word_res = (i_op == OP_SUBW) ? (i_a[31:0] - i_b[31:0]) : (i_a[31:0] + i_b[31:0]);

    always_comb begin
        if (op_is_word(i_op)) begin
            o_result = {{32{word_res[31]}}, word_res}; // sign-extend bit 31.
        end else begin
            case (i_op)
                OP_ADD: begin
                    o_result = i_a + i_b;
                end
                OP_SUB: begin
                    o_result = i_a - i_b;
                end
                OP_SLL: begin
                    o_result = i_a << shamt;
                end
                OP_SLT: begin
                    o_result = xlen_t'($signed(i_a) < $signed(i_b));
                end
                OP_SLTU: begin
                    o_result = xlen_t'(i_a < i_b);
                end
                OP_XOR: begin
                    o_result = i_a ^ i_b;
                end
                OP_SRL: begin
                    o_result = i_a >> shamt;
                end
                OP_SRA: begin
                    o_result = $signed(i_a) >>> shamt; // arithmetic, keeps sign.
                end
                OP_OR: begin
                    o_result = i_a | i_b;
                end
                OP_AND: begin
                    o_result = i_a & i_b;
                end
                default: begin
                    o_result = '0; // divu, remu and unused codes.
                end
            endcase
        end
    end

endmodule

/* verilog/rv_isa_pkg.sv */
// Operation codes 4'he and 4'hf are unused, and the integer ALU returns zero for them.
package rv_isa_pkg;

    typedef enum logic [3:0] {
        OP_ADD  = 4'h0,
        OP_SUB  = 4'h1,
        OP_SLL  = 4'h2,
        OP_SLT  = 4'h3,
        OP_SLTU = 4'h4,
        OP_XOR  = 4'h5,
        OP_SRL  = 4'h6,
        OP_SRA  = 4'h7,
        OP_OR   = 4'h8,
        OP_AND  = 4'h9,
        OP_ADDW = 4'ha, // 32-bit add, result sign-extended.
        OP_SUBW = 4'hb,
        OP_DIVU = 4'hc, // multi-cycle.
        OP_REMU = 4'hd
    } ex_op_e;

    // ops that go to the iterative divider instead of the alu.
    function automatic logic op_is_div(input ex_op_e op);
        return (op == OP_DIVU) || (op == OP_REMU);
    endfunction

    // word forms work on the low 32 bits only.
    function automatic logic op_is_word(input ex_op_e op);
        return (op == OP_ADDW) || (op == OP_SUBW);
    endfunction

endpackage
